// ==== run_sim.sh ====
#!/bin/sh
# Build and run the divider testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_div_top \
    -f sim.f \
    -o tb_div_top

./obj_dir/tb_div_top > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== sim.f ====
verilog/div_pkg.sv
verilog/div_data_path.sv
verilog/div_control.sv
verilog/div_top.sv
tb/div_top_sva.sv
tb/tb_div_top.sv

// ==== tb/div_top_sva.sv ====
//////////////////////////////////////////////////////////////////////
// Handshake and result assertions for the restoring divider
// Bound to div_top from the testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module div_top_sva (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic                       in_ready,
    input  logic                       out_valid,
    input  logic                       out_ready,
    input  logic [div_pkg::WIDTH-1:0]  quotient,
    input  logic [div_pkg::WIDTH-1:0]  remainder
);

    // out_valid is registered on edge WIDTH+1 after acceptance,
    // so its sampled value first shows high one edge later
    localparam int VALID_DELAY = div_pkg::WIDTH + 2;

    // Operand side and result side never open together
    handshake_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid are high in the same cycle");

    // Stalled result keeps valid and holds its value
    result_held: assert property (@(posedge clk) disable iff (!rst)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(quotient) && $stable(remainder)))
        else $error("Result changed or dropped while out_ready was low");

    // Fixed latency from the accepting edge
    valid_latency: assert property (@(posedge clk) disable iff (!rst)
        (in_valid && in_ready) |-> ##VALID_DELAY $rose(out_valid))
        else $error("out_valid did not rise WIDTH+1 edges after acceptance");

endmodule

// ==== tb/tb_div_top.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the restoring divider
// Clock, reset, watchdog, compare tasks, directed and random tests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_div_top;

    localparam int W = div_pkg::WIDTH;
    localparam int RANDOM_COUNT = 40;
    // Directed 6, divide by zero 3, back-pressure 3, random run
    localparam int NUM_DIVISIONS = 12 + RANDOM_COUNT;
    localparam int WATCHDOG_NS = NUM_DIVISIONS * (W + 10) * 40 + 100 * 40;
    localparam int HANDSHAKE_LIMIT = 4 * (W + 10);

    logic          clk;
    logic          rst;
    logic          in_valid;
    logic [W-1:0]  dividend;
    logic [W-1:0]  divisor;
    logic          in_ready;
    logic          out_valid;
    logic [W-1:0]  quotient;
    logic [W-1:0]  remainder;
    logic          out_ready;

    int            error_count;
    int            tests_passed;
    int            tests_failed;
    int            errors_at_start;
    logic [31:0]   rng_state;

    div_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .dividend  (dividend),
        .divisor   (divisor),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .quotient  (quotient),
        .remainder (remainder),
        .out_ready (out_ready)
    );

    // Protocol checks on every div_top instance
    bind div_top div_top_sva u_sva (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Upper bound on the whole run
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    // xorshift32
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Zero divisor gives all ones, otherwise integer division
    function automatic logic [W-1:0] expected_quotient(input logic [W-1:0] a,
                                                       input logic [W-1:0] b);
        if (b == '0) begin
            return '1;
        end
        return a / b;
    endfunction

    // Zero divisor leaves the dividend as remainder
    function automatic logic [W-1:0] expected_remainder(input logic [W-1:0] a,
                                                        input logic [W-1:0] b);
        if (b == '0) begin
            return a;
        end
        return a % b;
    endfunction

    task automatic check_quotient(input string name, input logic [W-1:0] expected,
                                  input logic [W-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch in %s: quotient expected %0d, actual %0d",
                     name, expected, actual);
        end
    endtask

    task automatic check_remainder(input string name, input logic [W-1:0] expected,
                                   input logic [W-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch in %s: remainder expected %0d, actual %0d",
                     name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch in %s: %s expected %b, actual %b", name, what, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            error_count++;
            $display("Mismatch in %s: latency expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Error: %s", msg);
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("Test %s finished without errors", name);
        end else begin
            tests_failed++;
            $display("Test %s finished with %0d errors", name, error_count - errors_at_start);
        end
    endtask

    // Called 2 ns after an edge, returns 2 ns after the accepting edge
    task automatic send_operands(input string name, input logic [W-1:0] a,
                                 input logic [W-1:0] b);
        int waited;
        in_valid = 1'b1;
        dividend = a;
        divisor = b;
        waited = 0;
        // in_ready is registered, stable until the next edge
        while (in_ready !== 1'b1 && waited < HANDSHAKE_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (in_ready !== 1'b1) begin
            report_failure($sformatf("%s: in_ready never rose for new operands", name));
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // Edges counted from acceptance until out_valid is seen
    task automatic wait_result(input string name, output logic [W-1:0] q,
                               output logic [W-1:0] r, output int latency);
        latency = 0;
        while (out_valid !== 1'b1 && latency < HANDSHAKE_LIMIT) begin
            @(posedge clk);
            #2;
            latency++;
        end
        if (out_valid !== 1'b1) begin
            report_failure($sformatf("%s: out_valid never rose after acceptance", name));
        end
        q = quotient;
        r = remainder;
    endtask

    // One transfer edge on the result side
    task automatic take_result(input logic keep_ready);
        out_ready = 1'b1;
        @(posedge clk);
        #2;
        out_ready = keep_ready;
    endtask

    task automatic divide_and_check(input string name, input logic [W-1:0] a,
                                    input logic [W-1:0] b, input logic keep_ready);
        logic [W-1:0] q;
        logic [W-1:0] r;
        int           latency;
        send_operands(name, a, b);
        wait_result(name, q, r, latency);
        check_latency(name, W + 1, latency);
        check_quotient(name, expected_quotient(a, b), q);
        check_remainder(name, expected_remainder(a, b), r);
        take_result(keep_ready);
    endtask

    task automatic test_reset_state();
        start_test();
        // rst is already low from time zero
        repeat (2) begin
            @(posedge clk);
            #2;
            check_flag("reset_state", "out_valid", 1'b0, out_valid);
            check_flag("reset_state", "in_ready", 1'b0, in_ready);
        end
        rst = 1'b1;
        @(posedge clk);
        #2;
        check_flag("reset_state", "in_ready", 1'b1, in_ready);
        check_flag("reset_state", "out_valid", 1'b0, out_valid);
        end_test("reset_state");
    endtask

    task automatic test_directed_values();
        start_test();
        divide_and_check("directed_values", W'(100), W'(7), 1'b0);
        // Dividend below divisor
        divide_and_check("directed_values", W'(5), W'(9), 1'b0);
        divide_and_check("directed_values", W'(42), W'(42), 1'b0);
        divide_and_check("directed_values", W'(200), W'(1), 1'b0);
        // Maximum dividend
        divide_and_check("directed_values", '1, W'(16), 1'b0);
        divide_and_check("directed_values", '1, '1, 1'b0);
        end_test("directed_values");
    endtask

    task automatic test_divide_by_zero();
        start_test();
        divide_and_check("divide_by_zero", W'(173), '0, 1'b0);
        divide_and_check("divide_by_zero", '1, '0, 1'b0);
        divide_and_check("divide_by_zero", '0, '0, 1'b0);
        end_test("divide_by_zero");
    endtask

    task automatic test_back_pressure();
        logic [31:0]  rnd;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] q;
        logic [W-1:0] r;
        int           latency;
        int           hold;
        start_test();
        out_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            rnd = next_random();
            a = rnd[W-1:0];
            b = rnd[2*W-1:W] | W'(1);
            hold = int'(rnd[27:24]) + 1;
            send_operands("back_pressure", a, b);
            wait_result("back_pressure", q, r, latency);
            check_quotient("back_pressure", expected_quotient(a, b), q);
            check_remainder("back_pressure", expected_remainder(a, b), r);
            // Sink stalls, result must stay put
            repeat (hold) begin
                @(posedge clk);
                #2;
                check_flag("back_pressure", "out_valid", 1'b1, out_valid);
                check_flag("back_pressure", "in_ready", 1'b0, in_ready);
                check_quotient("back_pressure", expected_quotient(a, b), quotient);
                check_remainder("back_pressure", expected_remainder(a, b), remainder);
            end
            take_result(1'b0);
            check_flag("back_pressure", "out_valid", 1'b0, out_valid);
            check_flag("back_pressure", "in_ready", 1'b1, in_ready);
        end
        end_test("back_pressure");
    endtask

    task automatic test_random_run();
        logic [31:0] rnd;
        start_test();
        out_ready = 1'b1;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            rnd = next_random();
            divide_and_check("random_run", rnd[W-1:0], rnd[2*W-1:W], 1'b1);
        end
        out_ready = 1'b0;
        end_test("random_run");
    endtask

    initial begin
        rst = 1'b0;
        in_valid = 1'b0;
        dividend = '0;
        divisor = '0;
        out_ready = 1'b0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        errors_at_start = 0;
        rng_state = 32'd25;

        test_reset_state();
        test_directed_values();
        test_divide_by_zero();
        test_back_pressure();
        test_random_run();

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/div_control.sv ====
//////////////////////////////////////////////////////////////////////
// Restoring divider controller
// Idle/run/done FSM, datapath strobes, operand and result handshakes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module div_control (
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    input  logic  out_ready,
    input  logic  count_done,
    output logic  in_ready,
    output logic  out_valid,
    output logic  load,
    output logic  step,
    output logic  capture
);

    div_pkg::div_state_t  state;
    div_pkg::div_state_t  state_next;

    // Handshake events
    logic  accept;
    logic  release_result;

    // Operand transfer on this edge
    assign accept = in_valid & in_ready;

    // Result transfer on this edge
    assign release_result = out_valid & out_ready;

    // Datapath strobes
    // load fires on the accepting edge itself
    assign load    = accept;
    // One step per cycle until the counter reports WIDTH
    assign step    = (state == div_pkg::ST_RUN) & ~count_done;
    // Final cycle of the run latches the result
    assign capture = (state == div_pkg::ST_RUN) & count_done;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            div_pkg::ST_IDLE: begin
                if (accept) begin
                    state_next = div_pkg::ST_RUN;
                end
            end
            div_pkg::ST_RUN: begin
                if (count_done) begin
                    state_next = div_pkg::ST_DONE;
                end
            end
            div_pkg::ST_DONE: begin
                // Hold the result until the sink takes it
                if (release_result) begin
                    state_next = div_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = div_pkg::ST_IDLE;
            end
        endcase
    end

    // State register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= div_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Registered handshake outputs, decoded from the next state
    // in_ready stays low in reset and rises on the first edge after it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            in_ready  <= (state_next == div_pkg::ST_IDLE);
            out_valid <= (state_next == div_pkg::ST_DONE);
        end
    end

endmodule

// ==== verilog/div_data_path.sv ====
//////////////////////////////////////////////////////////////////////
// Restoring divider datapath
// A/Q shift registers, divisor register, trial subtractor,
// restore select, iteration counter and result registers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module div_data_path (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [div_pkg::WIDTH-1:0]  dividend,
    input  logic [div_pkg::WIDTH-1:0]  divisor,
    input  logic                       load,
    input  logic                       step,
    input  logic                       capture,
    output logic [div_pkg::WIDTH-1:0]  quotient,
    output logic [div_pkg::WIDTH-1:0]  remainder,
    output logic                       count_done
);

    // Accumulator carries one extra bit for the trial sign
    logic [div_pkg::WIDTH:0]    acc_a;
    logic [div_pkg::WIDTH-1:0]  reg_q;
    logic [div_pkg::WIDTH-1:0]  reg_m;
    logic [div_pkg::CNT_W-1:0]  counter;

    // Shifted A/Q pair and trial difference
    logic [div_pkg::WIDTH:0]    shift_a;
    logic [div_pkg::WIDTH-1:0]  shift_q;
    logic [div_pkg::WIDTH:0]    diff;
    logic                       a_neg;

    // Next values after restore select
    logic [div_pkg::WIDTH:0]    next_a;
    logic [div_pkg::WIDTH-1:0]  next_q;

    // Left shift of {A, Q} by one
    // MSB of Q moves into the LSB of A
    assign shift_a = {acc_a[div_pkg::WIDTH-1:0], reg_q[div_pkg::WIDTH-1]};
    assign shift_q = {reg_q[div_pkg::WIDTH-2:0], 1'b0};

    // Trial subtract of the divisor, zero extended
    assign diff  = shift_a - {1'b0, reg_m};

    // Sign of the trial result
    assign a_neg = diff[div_pkg::WIDTH];

    // Restore select
    // Negative trial keeps the shifted A and a quotient bit of 0,
    // otherwise take the difference and set the quotient bit
    always_comb begin
        if (a_neg) begin
            next_a = shift_a;
            next_q = shift_q;
        end else begin
            next_a = diff;
            next_q = {shift_q[div_pkg::WIDTH-1:1], 1'b1};
        end
    end

    // Iteration counter
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            counter <= '0;
        end else if (load) begin
            counter <= '0;
        end else if (step) begin
            counter <= counter + 1'b1;
        end
    end

    // All WIDTH iterations complete
    assign count_done = (counter == div_pkg::CNT_W'(div_pkg::WIDTH));

    // Working registers A, Q and M
    always_ff @(posedge clk) begin
        if (load) begin
            // Dividend goes into Q, A starts from zero
            acc_a <= '0;
            reg_q <= dividend;
            reg_m <= divisor;
        end else if (step) begin
            acc_a <= next_a;
            reg_q <= next_q;
        end
    end

    // Result registers
    // Held until the next capture, so stable across back-pressure
    always_ff @(posedge clk) begin
        if (capture) begin
            quotient  <= reg_q;
            // A never exceeds the divisor, top bit is zero here
            remainder <= acc_a[div_pkg::WIDTH-1:0];
        end
    end

endmodule

// ==== verilog/div_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared definitions for the restoring divider
// Operand width, iteration counter width, controller state type
//////////////////////////////////////////////////////////////////////

package div_pkg;

    // Width of dividend, divisor, quotient and remainder
    localparam int WIDTH = 8;

    // Iteration counter must hold values up to WIDTH+1
    localparam int CNT_W = $clog2(WIDTH + 2);

    // Controller states
    // ST_IDLE waits for operands, ST_RUN iterates,
    // ST_DONE presents the result until it is taken
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } div_state_t;

endpackage

// ==== verilog/div_top.sv ====
//////////////////////////////////////////////////////////////////////
// Restoring divider top level
// Controller and datapath with valid/ready operand and result ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module div_top (
    input  logic                       clk,
    input  logic                       rst,

    // Operand side
    input  logic                       in_valid,
    input  logic [div_pkg::WIDTH-1:0]  dividend,
    input  logic [div_pkg::WIDTH-1:0]  divisor,
    output logic                       in_ready,

    // Result side
    output logic                       out_valid,
    output logic [div_pkg::WIDTH-1:0]  quotient,
    output logic [div_pkg::WIDTH-1:0]  remainder,
    input  logic                       out_ready
);

    // Controller to datapath strobes
    logic  load;
    logic  step;
    logic  capture;

    // Datapath status back to the controller
    logic  count_done;

    // Sequencing and handshakes
    div_control u_control (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .out_ready  (out_ready),
        .count_done (count_done),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .load       (load),
        .step       (step),
        .capture    (capture)
    );

    // Arithmetic and result registers
    div_data_path u_data_path (
        .clk        (clk),
        .rst        (rst),
        .dividend   (dividend),
        .divisor    (divisor),
        .load       (load),
        .step       (step),
        .capture    (capture),
        .quotient   (quotient),
        .remainder  (remainder),
        .count_done (count_done)
    );

endmodule
